//--- verilog/bus_pkg.sv
package bus_pkg;

    // bus and word widths
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;

    // word index into either memory, plus the byte offset below it
    localparam int MEM_INDEX_WIDTH = 6;
    localparam int BYTE_OFFSET_WIDTH = 2;
    // lowest address bit above one 256 byte region
    localparam int REGION_LSB = MEM_INDEX_WIDTH + BYTE_OFFSET_WIDTH;

    // memory sizes in words
    localparam int ROM_WORDS = 64;
    localparam int RAM_WORDS = 64;

    // address map
    localparam logic [ADDR_WIDTH-1:0] ROM_BASE = 32'h0000_0000;
    localparam logic [ADDR_WIDTH-1:0] RAM_BASE = 32'h0000_1000;

    // boot image, relative to the project root
    localparam string ROM_INIT_FILE = "verilog/boot_rom.hex";

    // controller states
    typedef enum logic [1:0] {
        state_idle,
        state_access,
        state_transmit
    } bus_state_t;

    // decoded target of a request
    typedef enum logic [1:0] {
        region_rom,
        region_ram,
        region_none
    } bus_region_t;

    // request direction
    typedef enum logic {
        op_read,
        op_write
    } bus_op_t;

endpackage

//--- verilog/bus_controller.sv
module bus_controller import bus_pkg::*; (
    input  logic                       clock,
    input  logic                       reset,
    // read side
    input  logic                       bus_read_valid,
    input  logic [ADDR_WIDTH-1:0]      bus_read_address,
    output logic                       bus_read_ready,
    output logic [DATA_WIDTH-1:0]      bus_read_data,
    // write side
    input  logic                       bus_write_valid,
    input  logic [ADDR_WIDTH-1:0]      bus_write_address,
    input  logic [DATA_WIDTH-1:0]      bus_write_data,
    output logic                       bus_write_ready,
    output logic                       bus_error,
    // memory side
    output logic [MEM_INDEX_WIDTH-1:0] memory_index,
    output logic                       rom_read_enable,
    input  logic [DATA_WIDTH-1:0]      rom_read_data,
    output logic                       ram_read_enable,
    output logic                       ram_write_enable,
    output logic [DATA_WIDTH-1:0]      ram_write_data,
    input  logic [DATA_WIDTH-1:0]      ram_read_data
);

    bus_state_t state;

    // delayed valid levels for edge detection
    logic read_valid_delay;
    logic write_valid_delay;
    logic read_rise;
    logic write_rise;

    // write edge seen while busy or alongside a read edge
    logic write_pending;

    // low in the memory cycle, high while waiting for read data
    logic memory_done;

    // request selected for the next access
    logic                  start_read;
    logic                  start_write;
    logic                  request_start;
    logic [ADDR_WIDTH-1:0] request_address;
    bus_op_t               request_op;
    bus_region_t           request_region;
    logic                  request_error;

    // latched request
    bus_op_t     latched_op;
    bus_region_t latched_region;
    logic        latched_error;
    logic        memory_cycle;

    // map a byte address onto one of the two 256 byte windows
    function automatic bus_region_t decode_region(input logic [ADDR_WIDTH-1:0] address);
        bus_region_t region;
        if (address[ADDR_WIDTH-1:REGION_LSB] == ROM_BASE[ADDR_WIDTH-1:REGION_LSB]) begin
            region = region_rom;
        end else if (address[ADDR_WIDTH-1:REGION_LSB] == RAM_BASE[ADDR_WIDTH-1:REGION_LSB]) begin
            region = region_ram;
        end else begin
            region = region_none;
        end
        return region;
    endfunction

    always_comb begin
        read_rise = bus_read_valid && !read_valid_delay;
        write_rise = bus_write_valid && !write_valid_delay;
        // read wins a tie, the write waits in the pending flag
        start_read = (state == state_idle) && read_rise;
        // a pending write starts on the edge that would return to idle
        start_write = (write_rise || write_pending) &&
                      (((state == state_idle) && !read_rise) || (state == state_transmit));
        request_start = start_read || start_write;
        request_address = start_read ? bus_read_address : bus_write_address;
        request_op = start_read ? op_read : op_write;
        request_region = decode_region(request_address);
        // unmapped, misaligned, or a store into the boot rom
        request_error = (request_region == region_none) ||
                        (request_address[BYTE_OFFSET_WIDTH-1:0] != '0) ||
                        ((request_op == op_write) && (request_region == region_rom));
    end

    // memory strobes only in the first access cycle of a good request
    assign memory_cycle = (state == state_access) && !memory_done && !latched_error;
    assign rom_read_enable = memory_cycle && (latched_region == region_rom) &&
                             (latched_op == op_read);
    assign ram_read_enable = memory_cycle && (latched_region == region_ram) &&
                             (latched_op == op_read);
    assign ram_write_enable = memory_cycle && (latched_region == region_ram) &&
                              (latched_op == op_write);

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= state_idle;
            read_valid_delay <= 1'b0;
            write_valid_delay <= 1'b0;
            write_pending <= 1'b0;
            memory_done <= 1'b0;
            latched_op <= op_read;
            latched_region <= region_none;
            latched_error <= 1'b0;
            bus_read_ready <= 1'b0;
            bus_write_ready <= 1'b0;
            bus_error <= 1'b0;
            bus_read_data <= '0;
        end else begin
            read_valid_delay <= bus_read_valid;
            write_valid_delay <= bus_write_valid;

            if (start_write) begin
                write_pending <= 1'b0;
            end else if (write_rise) begin
                write_pending <= 1'b1;
            end

            // E0 of any request
            if (request_start) begin
                latched_op <= request_op;
                latched_region <= request_region;
                latched_error <= request_error;
                memory_done <= 1'b0;
            end

            case (state)
                state_idle: begin
                    if (request_start) begin
                        state <= state_access;
                    end
                end
                state_access: begin
                    if (!memory_done) begin
                        // E1, memory performs the access
                        memory_done <= 1'b1;
                    end else begin
                        // E2, answer the requester
                        state <= state_transmit;
                        bus_read_ready <= (latched_op == op_read);
                        bus_write_ready <= (latched_op == op_write);
                        bus_error <= latched_error;
                        if (latched_op == op_read) begin
                            if (latched_error) begin
                                bus_read_data <= '0;
                            end else if (latched_region == region_rom) begin
                                bus_read_data <= rom_read_data;
                            end else begin
                                bus_read_data <= ram_read_data;
                            end
                        end
                    end
                end
                state_transmit: begin
                    // E3, ready was high for one cycle
                    bus_read_ready <= 1'b0;
                    bus_write_ready <= 1'b0;
                    bus_error <= 1'b0;
                    state <= request_start ? state_access : state_idle;
                end
                default: begin
                    state <= state_idle;
                end
            endcase
        end
    end

    // index and store data, taken with the request
    always_ff @(posedge clock) begin
        if (request_start) begin
            memory_index <= request_address[REGION_LSB-1:BYTE_OFFSET_WIDTH];
            ram_write_data <= bus_write_data;
        end
    end

endmodule

//--- verilog/boot_rom.sv
module boot_rom import bus_pkg::*; (
    input  logic                       clock,
    input  logic                       read_enable,
    input  logic [MEM_INDEX_WIDTH-1:0] read_index,
    output logic [DATA_WIDTH-1:0]      read_data
);

    logic [DATA_WIDTH-1:0] rom_memory [ROM_WORDS];

    // boot image
    initial begin
        $readmemh(ROM_INIT_FILE, rom_memory);
    end

    // registered read, holds between enables
    always_ff @(posedge clock) begin
        if (read_enable) begin
            read_data <= rom_memory[read_index];
        end
    end

endmodule

//--- verilog/data_ram.sv
module data_ram import bus_pkg::*; (
    input  logic                       clock,
    input  logic                       read_enable,
    input  logic                       write_enable,
    input  logic [MEM_INDEX_WIDTH-1:0] index,
    input  logic [DATA_WIDTH-1:0]      write_data,
    output logic [DATA_WIDTH-1:0]      read_data
);

    logic [DATA_WIDTH-1:0] ram_memory [RAM_WORDS];

    // word store
    always_ff @(posedge clock) begin
        if (write_enable) begin
            ram_memory[index] <= write_data;
        end
    end

    // registered read, one cycle after the enable
    always_ff @(posedge clock) begin
        if (read_enable) begin
            read_data <= ram_memory[index];
        end
    end

endmodule

//--- verilog/memory_bus_top.sv
module memory_bus_top import bus_pkg::*; (
    input  logic                  clock,
    input  logic                  reset,
    // read side
    input  logic                  bus_read_valid,
    input  logic [ADDR_WIDTH-1:0] bus_read_address,
    output logic                  bus_read_ready,
    output logic [DATA_WIDTH-1:0] bus_read_data,
    // write side
    input  logic                  bus_write_valid,
    input  logic [ADDR_WIDTH-1:0] bus_write_address,
    input  logic [DATA_WIDTH-1:0] bus_write_data,
    output logic                  bus_write_ready,
    output logic                  bus_error
);

    // controller to memories
    logic [MEM_INDEX_WIDTH-1:0] memory_index;
    logic                       rom_read_enable;
    logic                       ram_read_enable;
    logic                       ram_write_enable;
    logic [DATA_WIDTH-1:0]      ram_write_data;
    // memories back to controller
    logic [DATA_WIDTH-1:0]      rom_read_data;
    logic [DATA_WIDTH-1:0]      ram_read_data;

    bus_controller i_bus_controller (
        .clock             (clock),
        .reset             (reset),
        .bus_read_valid    (bus_read_valid),
        .bus_read_address  (bus_read_address),
        .bus_read_ready    (bus_read_ready),
        .bus_read_data     (bus_read_data),
        .bus_write_valid   (bus_write_valid),
        .bus_write_address (bus_write_address),
        .bus_write_data    (bus_write_data),
        .bus_write_ready   (bus_write_ready),
        .bus_error         (bus_error),
        .memory_index      (memory_index),
        .rom_read_enable   (rom_read_enable),
        .rom_read_data     (rom_read_data),
        .ram_read_enable   (ram_read_enable),
        .ram_write_enable  (ram_write_enable),
        .ram_write_data    (ram_write_data),
        .ram_read_data     (ram_read_data)
    );

    boot_rom i_boot_rom (
        .clock       (clock),
        .read_enable (rom_read_enable),
        .read_index  (memory_index),
        .read_data   (rom_read_data)
    );

    data_ram i_data_ram (
        .clock        (clock),
        .read_enable  (ram_read_enable),
        .write_enable (ram_write_enable),
        .index        (memory_index),
        .write_data   (ram_write_data),
        .read_data    (ram_read_data)
    );

endmodule

//--- verification/memory_bus_tb.sv
module memory_bus_tb import bus_pkg::*; ();

    // about 150 transactions of at most 9 cycles each plus margin
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int RAM_WRITES = 32;
    localparam int RAM_READS = 32;

    logic                  clock;
    logic                  reset;
    logic                  bus_read_valid;
    logic [ADDR_WIDTH-1:0] bus_read_address;
    logic                  bus_read_ready;
    logic [DATA_WIDTH-1:0] bus_read_data;
    logic                  bus_write_valid;
    logic [ADDR_WIDTH-1:0] bus_write_address;
    logic [DATA_WIDTH-1:0] bus_write_data;
    logic                  bus_write_ready;
    logic                  bus_error;

    int seed;
    int error_count = 0;
    int cycle_count = 0;

    // reference memories
    logic [DATA_WIDTH-1:0]      ref_rom [ROM_WORDS];
    logic [DATA_WIDTH-1:0]      ref_ram [RAM_WORDS];
    logic [MEM_INDEX_WIDTH-1:0] written [$];

    // expected answer of the request in flight on each side
    logic [DATA_WIDTH-1:0] expected_read_data;
    logic                  expected_read_error;
    logic                  expected_write_error;

    // cycles since each valid edge or zero when nothing is outstanding
    logic prev_read_valid;
    logic prev_write_valid;
    int   read_wait;
    int   write_wait;
    int   write_latency;

    memory_bus_top i_memory_bus_top (
        .clock             (clock),
        .reset             (reset),
        .bus_read_valid    (bus_read_valid),
        .bus_read_address  (bus_read_address),
        .bus_read_ready    (bus_read_ready),
        .bus_read_data     (bus_read_data),
        .bus_write_valid   (bus_write_valid),
        .bus_write_address (bus_write_address),
        .bus_write_data    (bus_write_data),
        .bus_write_ready   (bus_write_ready),
        .bus_error         (bus_error)
    );

    always #50 clock = ~clock;

    // rom and ram are 256 byte windows
    // stores into the rom are refused
    function automatic logic address_faults(input logic [ADDR_WIDTH-1:0] address,
                                            input logic is_write);
        logic [ADDR_WIDTH-1:0] rom_offset;
        logic [ADDR_WIDTH-1:0] ram_offset;
        rom_offset = address - ROM_BASE;
        ram_offset = address - RAM_BASE;
        return ((rom_offset >= ROM_WORDS * 4) && (ram_offset >= RAM_WORDS * 4)) ||
               (address[1:0] != 2'b00) || (is_write && (rom_offset < ROM_WORDS * 4));
    endfunction

    function automatic logic [DATA_WIDTH-1:0] model_read(input logic [ADDR_WIDTH-1:0] address);
        logic [ADDR_WIDTH-1:0] ram_offset;
        ram_offset = address - RAM_BASE;
        if (address_faults(address, 1'b0)) begin
            return '0;
        end else if (ram_offset < RAM_WORDS * 4) begin
            return ref_ram[ram_offset[7:2]];
        end
        return ref_rom[address[7:2]];
    endfunction

    function automatic logic [ADDR_WIDTH-1:0] word_address(input logic [ADDR_WIDTH-1:0] base,
                                                           input logic [MEM_INDEX_WIDTH-1:0] index);
        return base + ADDR_WIDTH'({index, 2'b00});
    endfunction

    // requester side tracking of edges and latency
    always @(posedge clock) begin
        if (reset) begin
            prev_read_valid <= 1'b0;
            prev_write_valid <= 1'b0;
            read_wait <= 0;
            write_wait <= 0;
            write_latency <= 3;
        end else begin
            prev_read_valid <= bus_read_valid;
            prev_write_valid <= bus_write_valid;
            if (bus_read_valid && !prev_read_valid) begin
                read_wait <= 1;
            end else if (bus_read_ready) begin
                read_wait <= 0;
            end else if (read_wait != 0) begin
                read_wait <= read_wait + 1;
            end
            if (bus_write_valid && !prev_write_valid) begin
                write_wait <= 1;
                // a write behind a read starts at the read's last edge
                if (bus_read_valid && !prev_read_valid) begin
                    write_latency <= 6;
                end else if (read_wait != 0) begin
                    write_latency <= 6 - read_wait;
                end else begin
                    write_latency <= 3;
                end
            end else if (bus_write_ready) begin
                write_wait <= 0;
            end else if (write_wait != 0) begin
                write_wait <= write_wait + 1;
            end
        end
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the bus did not finish the tests within %0d cycles",
                     TIMEOUT_CYCLES);
            $display("Errors: %0d, cycles: %0d", error_count, cycle_count);
            $display("Simulation failed");
            $finish;
        end
    end

    // data and error flag arrive with the read ready
    read_result: assert property (@(posedge clock) disable iff (reset)
        bus_read_ready |-> (bus_read_data == expected_read_data) &&
                           (bus_error == expected_read_error))
        else begin
            error_count++;
            $display("Error at %0t: read data %h error %b, expected %h error %b", $time,
                     $sampled(bus_read_data), $sampled(bus_error),
                     expected_read_data, expected_read_error);
        end

    write_result: assert property (@(posedge clock) disable iff (reset)
        bus_write_ready |-> bus_error == expected_write_error)
        else begin
            error_count++;
            $display("Error at %0t: write error flag %b, expected %b", $time,
                     $sampled(bus_error), expected_write_error);
        end

    // also catches a ready with no valid edge before it
    read_timing: assert property (@(posedge clock) disable iff (reset)
        bus_read_ready |-> read_wait == 3)
        else begin
            error_count++;
            $display("Error at %0t: read ready %0d cycles after the edge, expected 3",
                     $time, $sampled(read_wait));
        end

    write_timing: assert property (@(posedge clock) disable iff (reset)
        bus_write_ready |-> write_wait == write_latency)
        else begin
            error_count++;
            $display("Error at %0t: write ready %0d cycles after the edge, expected %0d",
                     $time, $sampled(write_wait), $sampled(write_latency));
        end

    // single cycle pulses and an error flag only alongside a ready
    ready_pulse: assert property (@(posedge clock) disable iff (reset)
        !(bus_read_ready && $past(bus_read_ready)) &&
        !(bus_write_ready && $past(bus_write_ready)) &&
        (!bus_error || bus_read_ready || bus_write_ready))
        else begin
            error_count++;
            $display("Error at %0t: ready held or error flag without ready", $time);
        end

    task automatic read_word(input logic [ADDR_WIDTH-1:0] address);
        @(negedge clock);
        expected_read_data = model_read(address);
        expected_read_error = address_faults(address, 1'b0);
        bus_read_address = address;
        bus_read_valid = 1'b1;
        @(negedge clock);
        while (!bus_read_ready) @(negedge clock);
        bus_read_valid = 1'b0;
    endtask

    task automatic write_word(input logic [ADDR_WIDTH-1:0] address,
                              input logic [DATA_WIDTH-1:0] data);
        @(negedge clock);
        expected_write_error = address_faults(address, 1'b1);
        bus_write_address = address;
        bus_write_data = data;
        bus_write_valid = 1'b1;
        @(negedge clock);
        while (!bus_write_ready) @(negedge clock);
        bus_write_valid = 1'b0;
        if (!expected_write_error) begin
            ref_ram[address[7:2]] = data;
        end
    endtask

    // write edge up to two cycles after the read edge with the read served first
    task automatic read_and_write(input logic [ADDR_WIDTH-1:0] read_address,
                                  input logic [ADDR_WIDTH-1:0] write_address,
                                  input logic [DATA_WIDTH-1:0] data,
                                  input int                    write_delay);
        @(negedge clock);
        expected_read_data = model_read(read_address);
        expected_read_error = address_faults(read_address, 1'b0);
        expected_write_error = address_faults(write_address, 1'b1);
        bus_read_address = read_address;
        bus_read_valid = 1'b1;
        repeat (write_delay) @(negedge clock);
        bus_write_address = write_address;
        bus_write_data = data;
        bus_write_valid = 1'b1;
        @(negedge clock);
        while (!bus_read_ready) @(negedge clock);
        bus_read_valid = 1'b0;
        while (!bus_write_ready) @(negedge clock);
        bus_write_valid = 1'b0;
        if (!expected_write_error) begin
            ref_ram[write_address[7:2]] = data;
        end
    endtask

    initial begin
        logic [MEM_INDEX_WIDTH-1:0] index;
        logic [MEM_INDEX_WIDTH-1:0] pick;
        logic [DATA_WIDTH-1:0]      data;
        seed = 32'hc3aa_811b;
        clock = 1'b0;
        reset = 1'b1;
        bus_read_valid = 1'b0;
        bus_read_address = '0;
        bus_write_valid = 1'b0;
        bus_write_address = '0;
        bus_write_data = '0;
        $readmemh(ROM_INIT_FILE, ref_rom);
        repeat (4) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        // quiet bus with no ready or error
        repeat (5) @(negedge clock);

        // whole boot image
        for (int i = 0; i < ROM_WORDS; i++) begin
            read_word(word_address(ROM_BASE, MEM_INDEX_WIDTH'(i)));
        end

        // random stores and then loads of stored words
        for (int i = 0; i < RAM_WRITES; i++) begin
            index = MEM_INDEX_WIDTH'($random(seed));
            data = $random(seed);
            write_word(word_address(RAM_BASE, index), data);
            written.push_back(index);
        end
        for (int i = 0; i < RAM_READS; i++) begin
            pick = written[$unsigned($random(seed)) % written.size()];
            read_word(word_address(RAM_BASE, pick));
        end

        // unmapped address, misaligned address and rom store
        read_word(32'h0000_2000);
        read_word(RAM_BASE + 32'h1);
        write_word(word_address(RAM_BASE, written[0]) + 32'h2, 32'hdead_beef);
        write_word(ROM_BASE + 32'h8, 32'h0bad_0bad);
        write_word(32'h0000_1100, 32'h1234_5678);
        // nothing may have changed
        read_word(word_address(RAM_BASE, written[0]));
        read_word(ROM_BASE + 32'h8);

        // colliding edges where odd rounds read the rom
        for (int i = 0; i < 4; i++) begin
            index = MEM_INDEX_WIDTH'($random(seed));
            data = $random(seed);
            pick = written[$unsigned($random(seed)) % written.size()];
            read_and_write(word_address((i % 2 == 0) ? RAM_BASE : ROM_BASE, pick),
                           word_address(RAM_BASE, index), data, i % 3);
            written.push_back(index);
            read_word(word_address(RAM_BASE, index));
        end

        repeat (5) @(negedge clock);
        $display("Errors: %0d, cycles: %0d", error_count, cycle_count);
        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- verilog/boot_rom.hex
// boot image, one 32-bit word per line, word 0 first
b000ffa5
b001fea4
b002fda7
b003fca6
b004fba1
b005faa0
b006f9a3
b007f8a2
b008f7ad
b009f6ac
b00af5af
b00bf4ae
b00cf3a9
b00df2a8
b00ef1ab
b00ff0aa
b010efb5
b011eeb4
b012edb7
b013ecb6
b014ebb1
b015eab0
b016e9b3
b017e8b2
b018e7bd
b019e6bc
b01ae5bf
b01be4be
b01ce3b9
b01de2b8
b01ee1bb
b01fe0ba
b020df85
b021de84
b022dd87
b023dc86
b024db81
b025da80
b026d983
b027d882
b028d78d
b029d68c
b02ad58f
b02bd48e
b02cd389
b02dd288
b02ed18b
b02fd08a
b030cf95
b031ce94
b032cd97
b033cc96
b034cb91
b035ca90
b036c993
b037c892
b038c79d
b039c69c
b03ac59f
b03bc49e
b03cc399
b03dc298
b03ec19b
b03fc09a

//--- flist.f
verilog/bus_pkg.sv
verilog/bus_controller.sv
verilog/boot_rom.sv
verilog/data_ram.sv
verilog/memory_bus_top.sv
verification/memory_bus_tb.sv

//--- Makefile
VERILATOR  ?= verilator
FILE_LIST  := flist.f
TOP        := memory_bus_tb
BUILD_DIR  := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert -j 0 --Mdir $(BUILD_DIR)
LOG        := sim.log
PASS_TEXT  := Simulation passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
